// File: design/e100_alu.sv
// purely combinational; shifts use op2[4:0] only, sr is logical, less is signed
`timescale 1ns/1ns
`default_nettype none

module e100_alu import e100_pkg::*; (
    input  wire word_t   op1,
    input  wire word_t   op2,
    input  wire alu_op_e alu_op,
    output word_t        result,
    output logic         equal,
    output logic         less
);

    always_comb begin
        unique case (alu_op)
            alu_add: result = op1 + op2;
            alu_sub: result = op1 - op2;
            alu_and: result = op1 & op2;
            alu_or:  result = op1 | op2;
            alu_not: result = ~op1;
            alu_sl:  result = op1 << op2[4:0];
            alu_sr:  result = op1 >> op2[4:0];
            default: result = '0;
        endcase
    end

    assign equal = (op1 == op2);
    // compare as two's complement
    assign less = ($signed(op1) < $signed(op2));

endmodule

`default_nettype wire

// File: design/e100_control.sv
// waits in reset state while run is low; unknown opcodes are skipped, halt is final
`timescale 1ns/1ns
`default_nettype none

module e100_control import e100_pkg::*; (
    input  wire          clock,
    input  wire          reset,
    input  wire          run,
    input  wire status_t status,
    output bus_ctrl_t    ctrl,
    output logic         halted
);

    state_e  state;
    state_e  next_state;
    alu_op_e exec_op;
    logic    is_cp;
    logic    take_branch;

    // operation for the final write of an arithmetic or logic instruction
    always_comb begin
        case (status.opcode)
            op_sub:  exec_op = alu_sub;
            op_and:  exec_op = alu_and;
            op_or:   exec_op = alu_or;
            op_not:  exec_op = alu_not;
            op_sl:   exec_op = alu_sl;
            op_sr:   exec_op = alu_sr;
            default: exec_op = alu_add;
        endcase
    end

    assign is_cp = (status.opcode == op_cp);

    always_comb begin
        case (status.opcode)
            op_be:   take_branch = status.equal;
            op_bne:  take_branch = !status.equal;
            default: take_branch = status.less;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.source = src_none;
        ctrl.alu_op = alu_add;
        next_state = st_reset;
        case (state)
            st_reset: begin
                next_state = run ? st_fetch1 : st_reset;
            end
            st_fetch1: begin
                ctrl.source = src_iar;
                ctrl.address_write = 1'b1;
                next_state = st_fetch2;
            end
            st_fetch2: begin
                ctrl.source = src_memory;
                ctrl.opcode_write = 1'b1;
                next_state = st_fetch3;
            end
            // step the IAR to the next argument word
            st_fetch3, st_fetch5, st_fetch7: begin
                ctrl.source = src_plus1;
                ctrl.iar_write = 1'b1;
                ctrl.address_write = 1'b1;
                next_state = (state == st_fetch3) ? st_fetch4 :
                             (state == st_fetch5) ? st_fetch6 : st_fetch8;
            end
            st_fetch4: begin
                ctrl.source = src_memory;
                ctrl.arg1_write = 1'b1;
                next_state = st_fetch5;
            end
            st_fetch6: begin
                ctrl.source = src_memory;
                ctrl.arg2_write = 1'b1;
                next_state = st_fetch7;
            end
            st_fetch8: begin
                ctrl.source = src_memory;
                ctrl.arg3_write = 1'b1;
                next_state = st_decode;
            end
            st_decode: begin
                // IAR now points at the following instruction
                ctrl.source = src_plus1;
                ctrl.iar_write = 1'b1;
                case (status.opcode)
                    op_halt: next_state = st_halt;
                    op_add, op_sub, op_and, op_or, op_sl, op_sr: next_state = st_calc1;
                    op_not, op_cp: next_state = st_unary1;
                    op_be, op_bne, op_blt: next_state = st_branch1;
                    default: next_state = st_fetch1;
                endcase
            end
            st_halt: begin
                next_state = st_halt;
            end
            st_calc1, st_unary1, st_branch1: begin
                ctrl.source = src_arg2;
                ctrl.address_write = 1'b1;
                next_state = (state == st_calc1) ? st_calc2 :
                             (state == st_unary1) ? st_unary2 : st_branch2;
            end
            st_calc2, st_branch2: begin
                ctrl.source = src_memory;
                ctrl.op1_write = 1'b1;
                next_state = (state == st_calc2) ? st_calc3 : st_branch3;
            end
            st_calc3, st_branch3: begin
                ctrl.source = src_arg3;
                ctrl.address_write = 1'b1;
                next_state = (state == st_calc3) ? st_calc4 : st_branch4;
            end
            st_calc4, st_branch4: begin
                ctrl.source = src_memory;
                ctrl.op2_write = 1'b1;
                next_state = (state == st_calc4) ? st_calc5 : st_branch5;
            end
            st_calc5, st_unary3: begin
                ctrl.source = src_arg1;
                ctrl.address_write = 1'b1;
                next_state = (state == st_calc5) ? st_calc6 : st_unary4;
            end
            st_calc6: begin
                ctrl.source = src_alu;
                ctrl.alu_op = exec_op;
                ctrl.memory_write = 1'b1;
                next_state = st_fetch1;
            end
            // cp parks the word in arg3, not goes through op1
            st_unary2: begin
                ctrl.source = src_memory;
                ctrl.arg3_write = is_cp;
                ctrl.op1_write = !is_cp;
                next_state = st_unary3;
            end
            st_unary4: begin
                ctrl.source = is_cp ? src_arg3 : src_alu;
                ctrl.alu_op = exec_op;
                ctrl.memory_write = 1'b1;
                next_state = st_fetch1;
            end
            st_branch5: begin
                next_state = take_branch ? st_branch6 : st_fetch1;
            end
            st_branch6: begin
                ctrl.source = src_arg1;
                ctrl.iar_write = 1'b1;
                next_state = st_fetch1;
            end
            default: begin
                next_state = st_reset;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    assign halted = (state == st_halt);

endmodule

`default_nettype wire

// File: design/e100_cpu.sv
// host may load only while run is low; peek_data is combinational and always valid
`timescale 1ns/1ns
`default_nettype none

module e100_cpu import e100_pkg::*; (
    input  wire        clock,
    input  wire        reset,
    input  wire        run,
    output logic       halted,
    input  wire        load_valid,
    input  wire addr_t load_address,
    input  wire word_t load_data,
    input  wire addr_t peek_address,
    output word_t      peek_data
);

    bus_ctrl_t ctrl;
    status_t   status;
    addr_t     mem_address;
    logic      mem_write;
    word_t     mem_write_data;
    word_t     mem_read_data;

    e100_control i_e100_control (
        .clock  (clock),
        .reset  (reset),
        .run    (run),
        .status (status),
        .ctrl   (ctrl),
        .halted (halted)
    );

    e100_datapath i_e100_datapath (
        .clock          (clock),
        .reset          (reset),
        .ctrl           (ctrl),
        .status         (status),
        .mem_address    (mem_address),
        .mem_write      (mem_write),
        .mem_write_data (mem_write_data),
        .mem_read_data  (mem_read_data)
    );

    e100_memory i_e100_memory (
        .clock        (clock),
        .address      (mem_address),
        .write        (mem_write),
        .write_data   (mem_write_data),
        .read_data    (mem_read_data),
        .load_valid   (load_valid),
        .load_address (load_address),
        .load_data    (load_data),
        .peek_address (peek_address),
        .peek_data    (peek_data)
    );

endmodule

`default_nettype wire

// File: design/e100_datapath.sv
// one shared bus; the address register keeps only the low 8 bits of the bus
`timescale 1ns/1ns
`default_nettype none

module e100_datapath import e100_pkg::*; (
    input  wire            clock,
    input  wire            reset,
    input  wire bus_ctrl_t ctrl,
    output status_t        status,
    output addr_t          mem_address,
    output logic           mem_write,
    output word_t          mem_write_data,
    input  wire word_t     mem_read_data
);

    word_t iar;
    word_t opcode;
    word_t arg1;
    word_t arg2;
    word_t arg3;
    word_t op1;
    word_t op2;
    addr_t address;
    word_t alu_result;
    word_t bus;

    e100_alu i_e100_alu (
        .op1    (op1),
        .op2    (op2),
        .alu_op (ctrl.alu_op),
        .result (alu_result),
        .equal  (status.equal),
        .less   (status.less)
    );

    // bus multiplexer
    always_comb begin
        unique case (ctrl.source)
            src_iar:    bus = iar;
            src_plus1:  bus = iar + 32'd1;
            src_alu:    bus = alu_result;
            src_arg1:   bus = arg1;
            src_arg2:   bus = arg2;
            src_arg3:   bus = arg3;
            src_memory: bus = mem_read_data;
            default:    bus = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            iar <= '0;
            opcode <= '0;
            arg1 <= '0;
            arg2 <= '0;
            arg3 <= '0;
            op1 <= '0;
            op2 <= '0;
            address <= '0;
        end else begin
            if (ctrl.iar_write) iar <= bus;
            if (ctrl.opcode_write) opcode <= bus;
            if (ctrl.arg1_write) arg1 <= bus;
            if (ctrl.arg2_write) arg2 <= bus;
            if (ctrl.arg3_write) arg3 <= bus;
            if (ctrl.op1_write) op1 <= bus;
            if (ctrl.op2_write) op2 <= bus;
            if (ctrl.address_write) address <= bus[$bits(addr_t)-1:0];
        end
    end

    assign status.opcode = opcode;
    assign mem_address = address;
    assign mem_write = ctrl.memory_write;
    assign mem_write_data = bus;

endmodule

`default_nettype wire

// File: design/e100_memory.sv
// no reset on contents; a processor write wins over a host load in the same cycle
`timescale 1ns/1ns
`default_nettype none

module e100_memory import e100_pkg::*; (
    input  wire        clock,
    input  wire addr_t address,
    input  wire        write,
    input  wire word_t write_data,
    output word_t      read_data,
    input  wire        load_valid,
    input  wire addr_t load_address,
    input  wire word_t load_data,
    input  wire addr_t peek_address,
    output word_t      peek_data
);

    word_t mem [0:mem_depth-1];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[address] <= write_data;
        end else if (load_valid) begin
            mem[load_address] <= load_data;
        end
    end

    // both read ports are asynchronous
    assign read_data = mem[address];
    assign peek_data = mem[peek_address];

endmodule

`default_nettype wire

// File: design/e100_pkg.sv
// shared types for the e100 core; mult, div, cpfa, cpta, call and ret are not supported
`default_nettype none

package e100_pkg;

    localparam int mem_depth = 256;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  addr_t;

    // opcode values as stored in the first word of an instruction
    typedef enum logic [31:0] {
        op_halt = 32'd0,
        op_add  = 32'd1,
        op_sub  = 32'd2,
        op_cp   = 32'd5,
        op_and  = 32'd6,
        op_or   = 32'd7,
        op_not  = 32'd8,
        op_sl   = 32'd9,
        op_sr   = 32'd10,
        op_be   = 32'd13,
        op_bne  = 32'd14,
        op_blt  = 32'd15
    } opcode_e;

    // who drives the shared bus
    typedef enum logic [2:0] {
        src_none,
        src_iar,
        src_plus1,
        src_alu,
        src_arg1,
        src_arg2,
        src_arg3,
        src_memory
    } bus_source_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_not,
        alu_sl,
        alu_sr
    } alu_op_e;

    typedef struct packed {
        bus_source_e source;
        alu_op_e     alu_op;
        logic        iar_write;
        logic        op1_write;
        logic        op2_write;
        logic        opcode_write;
        logic        arg1_write;
        logic        arg2_write;
        logic        arg3_write;
        logic        address_write;
        logic        memory_write;
    } bus_ctrl_t;

    typedef struct packed {
        word_t opcode;
        logic  equal;
        logic  less;
    } status_t;

    // two-operand ops share calc states, not and cp share unary states
    typedef enum logic [4:0] {
        st_reset,
        st_fetch1, st_fetch2, st_fetch3, st_fetch4,
        st_fetch5, st_fetch6, st_fetch7, st_fetch8,
        st_decode,
        st_halt,
        st_calc1, st_calc2, st_calc3, st_calc4, st_calc5, st_calc6,
        st_unary1, st_unary2, st_unary3, st_unary4,
        st_branch1, st_branch2, st_branch3, st_branch4, st_branch5, st_branch6
    } state_e;

endpackage

`default_nettype wire

// File: project.f
design/e100_pkg.sv
design/e100_alu.sv
design/e100_memory.sv
design/e100_datapath.sv
design/e100_control.sv
design/e100_cpu.sv
tb/e100_sva.sv
tb/e100_checker.sv
tb/tb_e100.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build/sim.log
mkdir -p build \
    && verilator --binary --timing --assert --top-module tb_e100 -f project.f \
        --Mdir build/obj -o sim_e100 > build/build.log 2>&1 \
    && ./build/obj/sim_e100 | tee build/sim.log \
    || { cat build/build.log; echo "build or simulation run failed"; exit 1; }
grep -q '^\*\*\* PASSED \*\*\*$' build/sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/e100_checker.sv
// starts reading back once halted is seen; memory must not change after halt
`timescale 1ns/1ns
`default_nettype none

module e100_checker import e100_pkg::*; (
    input  wire        clock,
    input  wire        halted,
    output addr_t      peek_address,
    input  wire word_t peek_data,
    output logic       done,
    output int         fail_count
);

    logic [8*16-1:0] check_name [$];
    addr_t           check_address [$];
    word_t           check_expected [$];

    task automatic add_check(input logic [8*16-1:0] name, input addr_t address,
                             input word_t expected);
        check_name.push_back(name);
        check_address.push_back(address);
        check_expected.push_back(expected);
    endtask

    initial begin
        int pass_count;
        pass_count = 0;
        fail_count = 0;
        done = 1'b0;
        peek_address <= '0;
        while (halted !== 1'b1) begin
            @(posedge clock);
        end
        // one word per cycle sampled an edge after its address is set
        foreach (check_address[i]) begin
            peek_address <= check_address[i];
            @(posedge clock);
            if (halted !== 1'b1) begin
                $display("%0s: halted dropped while reading back results", check_name[i]);
                fail_count = fail_count + 1;
            end else if (peek_data !== check_expected[i]) begin
                $display("Error %0s: peek_data at %h expected %h actual %h", check_name[i],
                         check_address[i], check_expected[i], peek_data);
                fail_count = fail_count + 1;
            end else begin
                $display("ok %0s: peek_data at %h = %h", check_name[i], check_address[i],
                         peek_data);
                pass_count = pass_count + 1;
            end
        end
        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        done = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/e100_sva.sv
// bound into every e100_control instance; needs concurrent assertion support
`timescale 1ns/1ns
`default_nettype none

module e100_sva import e100_pkg::*; (
    input wire            clock,
    input wire            reset,
    input wire            run,
    input wire state_e    state,
    input wire bus_ctrl_t ctrl,
    input wire            halted
);

    logic any_write;

    assign any_write = ctrl.iar_write | ctrl.op1_write | ctrl.op2_write |
                       ctrl.opcode_write | ctrl.arg1_write | ctrl.arg2_write |
                       ctrl.arg3_write | ctrl.address_write | ctrl.memory_write;

    // halt is final as long as run stays high
    halt_holds: assert property (@(posedge clock) disable iff (reset)
        (halted && run) |=> halted)
        else $error("halted fell while run was high");

    no_write_from_memory: assert property (@(posedge clock) disable iff (reset)
        !(ctrl.memory_write && (ctrl.source == src_memory)))
        else $error("memory write with memory as bus source");

    reset_quiet: assert property (@(posedge clock)
        reset |=> ((state == st_reset) && !any_write && (ctrl.source == src_none)))
        else $error("write enable or bus source active after reset");

endmodule

bind e100_control e100_sva i_e100_sva (
    .clock  (clock),
    .reset  (reset),
    .run    (run),
    .state  (state),
    .ctrl   (ctrl),
    .halted (halted)
);

`default_nettype wire

// File: tb/program_trace.txt
# header: load_line_count check_count instruction_budget, all decimal
# load line: address word0 word1 word2 word3 (hex); check line: name address expected (hex)
40 16 40
# arithmetic, logic, shifts and cp
00 1 e0 c0 c1
04 2 e1 c0 c1
08 6 e2 c2 c3
0c 7 e3 c2 c3
10 8 e4 c2 0
14 9 e5 c5 c4
18 a e6 c5 c4
1c 5 e7 c0 0
# branch tests: branch, not-taken marker, jump over, taken marker
20 d 2c c0 c1
24 5 e8 c8 0
28 d 30 c7 c7
2c 5 e8 c9 0
30 d 3c c0 c0
34 5 e9 ca 0
38 d 40 c7 c7
3c 5 e9 cb 0
40 e 4c c1 c1
44 5 ea cc 0
48 d 50 c7 c7
4c 5 ea cd 0
50 e 5c c0 c1
54 5 eb ce 0
58 d 60 c7 c7
5c 5 eb cf 0
60 f 6c c6 c0
64 5 ec d0 0
68 d 70 c7 c7
6c 5 ec d1 0
70 f 7c c0 c6
74 5 ed d2 0
78 d 80 c7 c7
7c 5 ed d3 0
# halt, then a cp that must never run
80 0 0 0 0
84 5 ef c0 0
# operands and markers
c0 00001234 00005678 f0f000ff 0ff0ff0f
c4 00000024 80000011 fffffffe 00000000
c8 b0000010 b0000011 b0000020 b0000021
cc b0000030 b0000031 b0000040 b0000041
d0 b0000050 b0000051 b0000060 b0000061
ec 00000000 00000000 00000000 5a5a5a5a
# expected words
add e0 000068ac
sub_wrap e1 ffffbbbc
and e2 00f0000f
or e3 fff0ffff
not e4 0f0fff00
sl e5 00000110
sr_logical e6 08000001
cp e7 00001234
cp_source c0 00001234
be_not_taken e8 b0000010
be_taken e9 b0000021
bne_not_taken ea b0000030
bne_taken eb b0000041
blt_taken ec b0000051
blt_not_taken ed b0000060
after_halt ef 5a5a5a5a

// File: tb/tb_e100.sv
// expects to run from the project root because the trace path tb/program_trace.txt is relative
`timescale 1ns/1ns
`default_nettype none

module tb_e100 import e100_pkg::*; ();

    logic  clock = 1'b0;
    logic  reset;
    logic  run;
    logic  halted;
    logic  load_valid;
    addr_t load_address;
    word_t load_data;
    addr_t peek_address;
    word_t peek_data;
    logic  done;
    int    fail_count;
    int    trace_fd;
    int    cycle_limit = 0;
    int    run_cycles = 0;
    addr_t image_address [$];
    word_t image_data [$];

    e100_cpu i_e100_cpu (
        .clock        (clock),
        .reset        (reset),
        .run          (run),
        .halted       (halted),
        .load_valid   (load_valid),
        .load_address (load_address),
        .load_data    (load_data),
        .peek_address (peek_address),
        .peek_data    (peek_data)
    );

    e100_checker i_e100_checker (
        .clock        (clock),
        .halted       (halted),
        .peek_address (peek_address),
        .peek_data    (peek_data),
        .done         (done),
        .fail_count   (fail_count)
    );

    always #4 clock = ~clock;

    // comment lines start with # and blank lines are skipped
    function automatic bit is_data_line(input string text);
        if (text.len() == 0) begin
            return 1'b0;
        end
        return (text.getc(0) != "#") && (text.getc(0) != "\n");
    endfunction

    task automatic next_data_line(output string text, output bit found);
        int count;
        found = 1'b0;
        text = "";
        while (!found && !$feof(trace_fd)) begin
            count = $fgets(text, trace_fd);
            found = (count > 0) && is_data_line(text);
        end
    endtask

    task automatic run_program();
        repeat (8) begin
            @(posedge clock);
        end
        reset <= 1'b0;
        foreach (image_address[i]) begin
            @(posedge clock);
            load_valid <= 1'b1;
            load_address <= image_address[i];
            load_data <= image_data[i];
        end
        @(posedge clock);
        load_valid <= 1'b0;
        run <= 1'b1;
        while (done !== 1'b1) begin
            @(posedge clock);
        end
    endtask

    initial begin
        string           text;
        bit              found;
        bit              trace_ok;
        int              fields;
        int              program_lines;
        int              check_count;
        int              budget;
        addr_t           base;
        word_t           words [4];
        logic [8*16-1:0] name;
        addr_t           address;
        word_t           expected;
        reset <= 1'b1;
        run <= 1'b0;
        load_valid <= 1'b0;
        load_address <= '0;
        load_data <= '0;
        trace_ok = 1'b0;
        trace_fd = $fopen("tb/program_trace.txt", "r");
        if (trace_fd != 0) begin
            next_data_line(text, found);
            fields = $sscanf(text, "%d %d %d", program_lines, check_count, budget);
            trace_ok = found && (fields == 3);
            cycle_limit = 16 * budget + 100;
            // each load line holds four consecutive words
            for (int i = 0; i < program_lines && trace_ok; i++) begin
                next_data_line(text, found);
                fields = $sscanf(text, "%h %h %h %h %h", base,
                                 words[0], words[1], words[2], words[3]);
                trace_ok = found && (fields == 5);
                for (int k = 0; k < 4; k++) begin
                    image_address.push_back(addr_t'(base + k));
                    image_data.push_back(words[k]);
                end
            end
            for (int i = 0; i < check_count && trace_ok; i++) begin
                next_data_line(text, found);
                fields = $sscanf(text, "%s %h %h", name, address, expected);
                trace_ok = found && (fields == 3);
                if (trace_ok) begin
                    i_e100_checker.add_check(name, address, expected);
                end
            end
            $fclose(trace_fd);
        end
        if (!trace_ok) begin
            $display("trace file tb/program_trace.txt is missing or malformed");
            $display("*** FAILED ***");
            $finish;
        end else begin
            run_program();
            if (fail_count == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

    // run time guard sized from the instruction budget in the trace
    always @(posedge clock) begin
        if (run === 1'b1) begin
            run_cycles <= run_cycles + 1;
            if (run_cycles >= cycle_limit) begin
                $display("timeout: program did not halt and finish checks in %0d cycles",
                         run_cycles);
                $display("*** FAILED ***");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire
